// ==== rtl/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

    // station geometry
    localparam int RS_DEPTH   = 8;
    localparam int RS_IDX_W   = 3;
    localparam int NUM_PORTS  = 3;
    localparam int NUM_CDB    = NUM_PORTS + 1;
    // port 0 covers entries 0..PORT0_LAST, the rest get one entry each
    localparam int PORT0_LAST = RS_DEPTH - NUM_PORTS;

    // tag zero means no producer
    localparam int TAG_W    = 4;
    localparam int XLEN     = 32;
    localparam int CREDIT_W = 4;
    localparam int RET_W    = 2;
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd7;

    // operand word, value once ready, producer tag while waiting
    typedef union packed {
        logic [XLEN-1:0] value;
        struct packed {
            logic [XLEN-TAG_W-1:0] pad;
            logic [TAG_W-1:0]      tag;
        } wait_tag;
    } rs_operand_u;

endpackage

`default_nettype wire

// ==== rtl/rs_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_ctrl (
    input  wire                                             clk,
    input  wire                                             rst,
    input  wire                                             flush,
    input  wire                                             disp_valid,
    input  wire  [rs_pkg::NUM_PORTS-1:0]                    issue_valid,
    input  wire  [rs_pkg::NUM_PORTS-1:0][rs_pkg::RS_IDX_W-1:0] issue_idx,
    output logic [rs_pkg::RS_DEPTH-1:0]                     busy,
    output logic                                            alloc_en,
    output logic [rs_pkg::RS_IDX_W-1:0]                     alloc_idx,
    output logic [rs_pkg::RET_W-1:0]                        credit_ret
);

    logic [rs_pkg::RS_DEPTH-1:0] busy_q;
    logic [rs_pkg::RS_DEPTH-1:0] released;
    logic [rs_pkg::RS_DEPTH-1:0] alloc_mask;
    logic                        free_any;
    logic [rs_pkg::RET_W-1:0]    ret_sum;

    // entries handed to a port at the last edge
    always_comb begin
        released = '0;
        for (int p = 0; p < rs_pkg::NUM_PORTS; p++) begin
            if (issue_valid[p]) begin
                released[issue_idx[p]] = 1'b1;
            end
        end
    end

    // issued entries drop out right after the issue edge
    assign busy = busy_q & ~released;

    // lowest free slot
    always_comb begin
        free_any  = 1'b0;
        alloc_idx = '0;
        for (int i = rs_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_any  = 1'b1;
                alloc_idx = i[rs_pkg::RS_IDX_W-1:0];
            end
        end
    end

    assign alloc_en = disp_valid & free_any & ~flush;

    always_comb begin
        alloc_mask = '0;
        if (alloc_en) begin
            alloc_mask[alloc_idx] = 1'b1;
        end
    end

    always_comb begin
        ret_sum = '0;
        for (int p = 0; p < rs_pkg::NUM_PORTS; p++) begin
            ret_sum = ret_sum + {{(rs_pkg::RET_W - 1){1'b0}}, issue_valid[p]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q     <= '0;
            credit_ret <= '0;
        end else if (flush) begin
            // dispatcher restores its own credits on flush
            busy_q     <= '0;
            credit_ret <= '0;
        end else begin
            busy_q     <= busy | alloc_mask;
            credit_ret <= ret_sum;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rs_entry_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_entry_file (
    input  wire                                               clk,
    input  wire                                               rst,
    input  wire                                               alloc_en,
    input  wire  [rs_pkg::RS_IDX_W-1:0]                       alloc_idx,
    input  wire  [rs_pkg::TAG_W-1:0]                          disp_tag,
    input  wire  [rs_pkg::ALU_OP_W-1:0]                       disp_alu_op,
    input  wire                                               disp_use_imm,
    input  wire  [rs_pkg::XLEN-1:0]                           disp_imm,
    input  wire  rs_pkg::rs_operand_u                         disp_src1,
    input  wire                                               disp_src1_ready,
    input  wire  rs_pkg::rs_operand_u                         disp_src2,
    input  wire                                               disp_src2_ready,
    input  wire  [rs_pkg::RS_DEPTH-1:0]                       busy,
    input  wire  [rs_pkg::NUM_CDB-1:0]                        cdb_valid,
    input  wire  [rs_pkg::NUM_CDB-1:0][rs_pkg::TAG_W-1:0]     cdb_tag,
    input  wire  [rs_pkg::NUM_CDB-1:0][rs_pkg::XLEN-1:0]      cdb_value,
    output logic [rs_pkg::RS_DEPTH-1:0]                       entry_ready,
    output logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::ALU_OP_W-1:0] ent_op,
    output logic [rs_pkg::RS_DEPTH-1:0]                       ent_use_imm,
    output logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]     ent_imm,
    output logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::TAG_W-1:0]    ent_tag,
    output logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]     ent_a,
    output logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]     ent_b
);

    rs_pkg::rs_operand_u         src1_q [rs_pkg::RS_DEPTH];
    rs_pkg::rs_operand_u         src2_q [rs_pkg::RS_DEPTH];
    rs_pkg::rs_operand_u         src1_d [rs_pkg::RS_DEPTH];
    rs_pkg::rs_operand_u         src2_d [rs_pkg::RS_DEPTH];
    logic [rs_pkg::RS_DEPTH-1:0] rdy1_q;
    logic [rs_pkg::RS_DEPTH-1:0] rdy2_q;
    logic [rs_pkg::RS_DEPTH-1:0] rdy1_d;
    logic [rs_pkg::RS_DEPTH-1:0] rdy2_d;

    // compare a waiting operand against every lane, lowest lane wins
    function automatic logic [rs_pkg::XLEN:0] snoop(
        input rs_pkg::rs_operand_u opnd,
        input logic                rdy
    );
        logic [rs_pkg::XLEN:0] res;
        res = {rdy, opnd};
        if (!rdy) begin
            for (int l = rs_pkg::NUM_CDB - 1; l >= 0; l--) begin
                if (cdb_valid[l] && cdb_tag[l] == opnd.wait_tag.tag) begin
                    res = {1'b1, cdb_value[l]};
                end
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            if (alloc_en && alloc_idx == i[rs_pkg::RS_IDX_W-1:0]) begin
                // bypass from the lanes in the dispatch cycle
                {rdy1_d[i], src1_d[i]} = snoop(disp_src1, disp_src1_ready);
                {rdy2_d[i], src2_d[i]} = snoop(disp_src2, disp_src2_ready);
            end else if (busy[i]) begin
                {rdy1_d[i], src1_d[i]} = snoop(src1_q[i], rdy1_q[i]);
                {rdy2_d[i], src2_d[i]} = snoop(src2_q[i], rdy2_q[i]);
            end else begin
                {rdy1_d[i], src1_d[i]} = {rdy1_q[i], src1_q[i]};
                {rdy2_d[i], src2_d[i]} = {rdy2_q[i], src2_q[i]};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdy1_q <= '0;
            rdy2_q <= '0;
        end else begin
            rdy1_q <= rdy1_d;
            rdy2_q <= rdy2_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            src1_q[i] <= src1_d[i];
            src2_q[i] <= src2_d[i];
            if (alloc_en && alloc_idx == i[rs_pkg::RS_IDX_W-1:0]) begin
                ent_op[i]      <= disp_alu_op;
                ent_use_imm[i] <= disp_use_imm;
                ent_imm[i]     <= disp_imm;
                ent_tag[i]     <= disp_tag;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            ent_a[i] = src1_q[i].value;
            ent_b[i] = src2_q[i].value;
        end
    end

    assign entry_ready = busy & rdy1_q & rdy2_q;

endmodule

`default_nettype wire

// ==== rtl/rs_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_select (
    input  wire                                                clk,
    input  wire                                                rst,
    input  wire                                                flush,
    input  wire  [rs_pkg::RS_DEPTH-1:0]                        entry_ready,
    input  wire  [rs_pkg::RS_DEPTH-1:0][rs_pkg::ALU_OP_W-1:0]  ent_op,
    input  wire  [rs_pkg::RS_DEPTH-1:0]                        ent_use_imm,
    input  wire  [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]      ent_imm,
    input  wire  [rs_pkg::RS_DEPTH-1:0][rs_pkg::TAG_W-1:0]     ent_tag,
    input  wire  [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]      ent_a,
    input  wire  [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]      ent_b,
    output logic [rs_pkg::NUM_PORTS-1:0]                       issue_valid,
    output logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::RS_IDX_W-1:0] issue_idx,
    output logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::TAG_W-1:0]    port_tag,
    output logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::ALU_OP_W-1:0] port_op,
    output logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::XLEN-1:0]     port_a,
    output logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::XLEN-1:0]     port_b
);

    logic [rs_pkg::NUM_PORTS-1:0]                       sel_valid;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::RS_IDX_W-1:0] sel_idx;

    always_comb begin
        sel_valid = '0;
        sel_idx   = '0;
        // port 0 takes the lowest ready index of its range
        for (int i = rs_pkg::PORT0_LAST; i >= 0; i--) begin
            if (entry_ready[i]) begin
                sel_valid[0] = 1'b1;
                sel_idx[0]   = i[rs_pkg::RS_IDX_W-1:0];
            end
        end
        // remaining ports own a single entry each
        for (int p = 1; p < rs_pkg::NUM_PORTS; p++) begin
            sel_valid[p] = entry_ready[rs_pkg::PORT0_LAST + p];
            sel_idx[p]   = rs_pkg::RS_IDX_W'(rs_pkg::PORT0_LAST + p);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= '0;
            issue_idx   <= '0;
        end else begin
            issue_valid <= flush ? '0 : sel_valid;
            issue_idx   <= sel_idx;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < rs_pkg::NUM_PORTS; p++) begin
            port_tag[p] <= ent_tag[sel_idx[p]];
            port_op[p]  <= ent_op[sel_idx[p]];
            port_a[p]   <= ent_a[sel_idx[p]];
            port_b[p]   <= ent_use_imm[sel_idx[p]] ? ent_imm[sel_idx[p]] : ent_b[sel_idx[p]];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flush,
    input  wire                          in_valid,
    input  wire  [rs_pkg::TAG_W-1:0]     in_tag,
    input  wire  [rs_pkg::ALU_OP_W-1:0]  in_op,
    input  wire  [rs_pkg::XLEN-1:0]      in_a,
    input  wire  [rs_pkg::XLEN-1:0]      in_b,
    output logic                         out_valid,
    output logic [rs_pkg::TAG_W-1:0]     out_tag,
    output logic [rs_pkg::XLEN-1:0]      out_value
);

    logic [rs_pkg::XLEN-1:0] result;
    logic [4:0]              shamt;

    // shifts only look at the low five bits of b
    assign shamt = in_b[4:0];

    always_comb begin
        case (in_op)
            rs_pkg::ALU_ADD: result = in_a + in_b;
            rs_pkg::ALU_SUB: result = in_a - in_b;
            rs_pkg::ALU_AND: result = in_a & in_b;
            rs_pkg::ALU_OR:  result = in_a | in_b;
            rs_pkg::ALU_XOR: result = in_a ^ in_b;
            rs_pkg::ALU_SLL: result = in_a << shamt;
            rs_pkg::ALU_SRL: result = in_a >> shamt;
            rs_pkg::ALU_SLT: begin
                result = {{(rs_pkg::XLEN - 1){1'b0}}, $signed(in_a) < $signed(in_b)};
            end
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            // results in flight are dropped by a flush
            out_valid <= in_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        out_tag   <= in_tag;
        out_value <= result;
    end

endmodule

`default_nettype wire

// ==== rtl/rs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_top (
    input  wire                                              clk,
    input  wire                                              rst,
    input  wire                                              flush,
    input  wire                                              disp_valid,
    input  wire  [rs_pkg::TAG_W-1:0]                         disp_tag,
    input  wire  [rs_pkg::ALU_OP_W-1:0]                      disp_alu_op,
    input  wire                                              disp_use_imm,
    input  wire  [rs_pkg::XLEN-1:0]                          disp_imm,
    input  wire  rs_pkg::rs_operand_u                        disp_src1,
    input  wire                                              disp_src1_ready,
    input  wire  rs_pkg::rs_operand_u                        disp_src2,
    input  wire                                              disp_src2_ready,
    input  wire                                              ext_cdb_valid,
    input  wire  [rs_pkg::TAG_W-1:0]                         ext_cdb_tag,
    input  wire  [rs_pkg::XLEN-1:0]                          ext_cdb_value,
    output logic [rs_pkg::RET_W-1:0]                         credit_ret,
    output logic [rs_pkg::NUM_PORTS-1:0]                     res_valid,
    output logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::TAG_W-1:0]  res_tag,
    output logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::XLEN-1:0]   res_value
);

    logic [rs_pkg::RS_DEPTH-1:0]                        busy;
    logic                                               alloc_en;
    logic [rs_pkg::RS_IDX_W-1:0]                        alloc_idx;
    logic [rs_pkg::RS_DEPTH-1:0]                        entry_ready;
    logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::ALU_OP_W-1:0]  ent_op;
    logic [rs_pkg::RS_DEPTH-1:0]                        ent_use_imm;
    logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]      ent_imm;
    logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::TAG_W-1:0]     ent_tag;
    logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]      ent_a;
    logic [rs_pkg::RS_DEPTH-1:0][rs_pkg::XLEN-1:0]      ent_b;
    logic [rs_pkg::NUM_PORTS-1:0]                       issue_valid;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::RS_IDX_W-1:0] issue_idx;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::TAG_W-1:0]    port_tag;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::ALU_OP_W-1:0] port_op;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::XLEN-1:0]     port_a;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::XLEN-1:0]     port_b;

    rs_ctrl u_ctrl (
        .clk, .rst, .flush, .disp_valid, .issue_valid, .issue_idx,
        .busy, .alloc_en, .alloc_idx, .credit_ret
    );

    // lane 0 is the external load lane, lanes 1..3 are the ALUs
    rs_entry_file u_entries (
        .clk, .rst, .alloc_en, .alloc_idx,
        .disp_tag, .disp_alu_op, .disp_use_imm, .disp_imm,
        .disp_src1, .disp_src1_ready, .disp_src2, .disp_src2_ready,
        .busy,
        .cdb_valid   ({res_valid, ext_cdb_valid}),
        .cdb_tag     ({res_tag, ext_cdb_tag}),
        .cdb_value   ({res_value, ext_cdb_value}),
        .entry_ready, .ent_op, .ent_use_imm, .ent_imm, .ent_tag, .ent_a, .ent_b
    );

    rs_select u_select (
        .clk, .rst, .flush, .entry_ready,
        .ent_op, .ent_use_imm, .ent_imm, .ent_tag, .ent_a, .ent_b,
        .issue_valid, .issue_idx, .port_tag, .port_op, .port_a, .port_b
    );

    for (genvar p = 0; p < rs_pkg::NUM_PORTS; p++) begin : g_alu
        alu_unit u_alu (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .in_valid  (issue_valid[p]),
            .in_tag    (port_tag[p]),
            .in_op     (port_op[p]),
            .in_a      (port_a[p]),
            .in_b      (port_b[p]),
            .out_valid (res_valid[p]),
            .out_tag   (res_tag[p]),
            .out_value (res_value[p])
        );
    end

endmodule

`default_nettype wire

// ==== tests/rs_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_chk (
    input wire                         clk,
    input wire                         rst,
    input wire                         flush,
    input wire                         disp_valid,
    input wire [rs_pkg::RET_W-1:0]     credit_ret,
    input wire [rs_pkg::NUM_PORTS-1:0] res_valid
);

    // dispatcher credits rebuilt from the handshake
    logic [rs_pkg::CREDIT_W:0] credits;

    always_ff @(posedge clk or posedge rst) begin
        if (rst || flush) begin
            credits <= (rs_pkg::CREDIT_W + 1)'(rs_pkg::RS_DEPTH);
        end else begin
            credits <= credits - {{rs_pkg::CREDIT_W{1'b0}}, disp_valid}
                       + {{(rs_pkg::CREDIT_W + 1 - rs_pkg::RET_W){1'b0}}, credit_ret};
        end
    end

    credit_held: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> credits != '0)
        else $error("dispatch raised with no credit left");

    // a freed entry hands back its credit together with its result
    return_bounded: assert property (@(posedge clk) disable iff (rst)
        credit_ret <= $countones(res_valid))
        else $error("credit return larger than the results of the cycle");

    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= (rs_pkg::CREDIT_W + 1)'(rs_pkg::RS_DEPTH))
        else $error("credit total above the station depth");

    flush_quiet: assert property (@(posedge clk) disable iff (rst)
        flush |=> res_valid == '0)
        else $error("result valid in the cycle after a flush");

endmodule

bind rs_top rs_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .disp_valid (disp_valid),
    .credit_ret (credit_ret),
    .res_valid  (res_valid)
);

`default_nettype wire

// ==== tests/rs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_tb;

    logic                                            clk;
    logic                                            rst;
    logic                                            flush;
    logic                                            disp_valid;
    logic [rs_pkg::TAG_W-1:0]                        disp_tag;
    logic [rs_pkg::ALU_OP_W-1:0]                     disp_alu_op;
    logic                                            disp_use_imm;
    logic [rs_pkg::XLEN-1:0]                         disp_imm;
    rs_pkg::rs_operand_u                             disp_src1;
    logic                                            disp_src1_ready;
    rs_pkg::rs_operand_u                             disp_src2;
    logic                                            disp_src2_ready;
    logic                                            ext_cdb_valid;
    logic [rs_pkg::TAG_W-1:0]                        ext_cdb_tag;
    logic [rs_pkg::XLEN-1:0]                         ext_cdb_value;
    logic [rs_pkg::RET_W-1:0]                        credit_ret;
    logic [rs_pkg::NUM_PORTS-1:0]                    res_valid;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::TAG_W-1:0] res_tag;
    logic [rs_pkg::NUM_PORTS-1:0][rs_pkg::XLEN-1:0]  res_value;

    // scoreboard per tag, the top tag belongs to the external lane
    logic [rs_pkg::XLEN-1:0]     exp_val [2**rs_pkg::TAG_W];
    logic [2**rs_pkg::TAG_W-1:0] pending;
    logic [2**rs_pkg::TAG_W-1:0] done;
    logic [rs_pkg::TAG_W-1:0]    ext_tag;
    logic [rs_pkg::TAG_W-1:0]    tag_ctr;
    logic [31:0]                 lfsr;
    logic                        quiet;
    int                          credits;
    int                          errors;
    int                          checks;
    int                          cycle_count;

    rs_top dut (.*);

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        logic        fb;
        w = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w    = {w[30:0], fb};
        end
        return w;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            rs_pkg::ALU_ADD: return a + b;
            rs_pkg::ALU_SUB: return a - b;
            rs_pkg::ALU_AND: return a & b;
            rs_pkg::ALU_OR:  return a | b;
            rs_pkg::ALU_XOR: return a ^ b;
            rs_pkg::ALU_SLL: return a << b[4:0];
            rs_pkg::ALU_SRL: return a >> b[4:0];
            rs_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         return '0;
        endcase
    endfunction

    function automatic rs_pkg::rs_operand_u make_operand(input logic rdy,
                                                         input logic [31:0] val,
                                                         input logic [3:0] tag);
        rs_pkg::rs_operand_u o;
        o.value = val;
        if (!rdy) begin
            o.wait_tag.pad = '0;
            o.wait_tag.tag = tag;
        end
        return o;
    endfunction

    // results and credit flow of the current cycle, sampled mid-cycle
    task automatic observe();
        logic [rs_pkg::TAG_W-1:0] t;
        for (int p = 0; p < rs_pkg::NUM_PORTS; p++) begin
            if (res_valid[p]) begin
                t = res_tag[p];
                checks++;
                assert (pending[t] && !quiet) else begin
                    $display("%0t: result for tag %0d came with no such instruction in flight",
                             $time, t);
                    errors++;
                end
                assert (res_value[p] == exp_val[t]) else begin
                    $display("[FAIL] %0t res_value[%0d] got %h expected %h",
                             $time, p, res_value[p], exp_val[t]);
                    errors++;
                end
                pending[t] = 1'b0;
                done[t]    = 1'b1;
            end
        end
        credits = (rst || flush) ? rs_pkg::RS_DEPTH
                                 : credits - int'(disp_valid) + int'(credit_ret);
    endtask

    task automatic step();
        @(negedge clk);
        observe();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_credits(input int n);
        checks++;
        assert (credits == n) else begin
            $display("[FAIL] %0t credits got %0d expected %0d", $time, credits, n);
            errors++;
        end
    endtask

    // a zero producer tag means the given value is used
    task automatic dispatch(input logic [3:0] op, input logic use_imm, input logic [31:0] imm,
                            input logic [3:0] p1, input logic [31:0] v1,
                            input logic [3:0] p2, input logic [31:0] v2,
                            output logic [3:0] tag);
        logic [31:0] a;
        logic [31:0] b;
        logic        r1;
        logic        r2;
        while (credits == 0) begin
            step();
        end
        do begin
            tag_ctr = (tag_ctr + 4'd1 == ext_tag) ? 4'd1 : tag_ctr + 4'd1;
        end while (pending[tag_ctr]);
        tag = tag_ctr;
        r1  = (p1 == '0) || done[p1];
        r2  = (p2 == '0) || done[p2];
        a   = (p1 == '0) ? v1 : exp_val[p1];
        b   = (p2 == '0) ? v2 : exp_val[p2];
        exp_val[tag] = alu_ref(op, a, use_imm ? imm : b);
        pending[tag] = 1'b1;
        done[tag]    = 1'b0;
        disp_valid      = 1'b1;
        disp_tag        = tag;
        disp_alu_op     = op;
        disp_use_imm    = use_imm;
        disp_imm        = imm;
        disp_src1       = make_operand(r1, a, p1);
        disp_src1_ready = r1;
        disp_src2       = make_operand(r2, b, p2);
        disp_src2_ready = r2;
        step();
        disp_valid = 1'b0;
    endtask

    task automatic ext_send();
        ext_cdb_valid = 1'b1;
        ext_cdb_tag   = ext_tag;
        ext_cdb_value = exp_val[ext_tag];
        step();
        ext_cdb_valid = 1'b0;
        done[ext_tag] = 1'b1;
    endtask

    task automatic drain();
        while (pending != '0) begin
            step();
        end
        repeat (2) step();
    endtask

    initial begin
        logic [rs_pkg::TAG_W-1:0] t1;
        logic [rs_pkg::TAG_W-1:0] t2;
        logic [rs_pkg::TAG_W-1:0] t3;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        disp_valid = 1'b0;
        disp_tag = '0;
        disp_alu_op = '0;
        disp_use_imm = 1'b0;
        disp_imm = '0;
        disp_src1 = '0;
        disp_src1_ready = 1'b0;
        disp_src2 = '0;
        disp_src2_ready = 1'b0;
        ext_cdb_valid = 1'b0;
        ext_cdb_tag = '0;
        ext_cdb_value = '0;
        lfsr = 32'hb96e;
        pending = '0;
        done = '0;
        ext_tag = '1;
        tag_ctr = '0;
        quiet = 1'b0;
        credits = rs_pkg::RS_DEPTH;
        errors = 0;
        checks = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // every operation, register form first and then immediate form
        for (int k = 0; k < 16; k++) begin
            dispatch(4'(k % 8), k >= 8, rand_bits(32), '0, rand_bits(32), '0, rand_bits(32), t1);
        end
        drain();

        // station is empty, so the producer lands in entry 0 on port 0
        dispatch(rs_pkg::ALU_ADD, 1'b0, '0, '0, rand_bits(32), '0, rand_bits(32), t1);
        while (!(res_valid[0] && res_tag[0] == t1)) begin
            step();
        end
        dispatch(rs_pkg::ALU_SUB, 1'b0, '0, t1, '0, '0, rand_bits(32), t2);
        dispatch(rs_pkg::ALU_XOR, 1'b1, rand_bits(32), t2, '0, '0, '0, t3);
        dispatch(rs_pkg::ALU_SLT, 1'b0, '0, t3, '0, t1, '0, t2);
        dispatch(rs_pkg::ALU_OR, 1'b0, '0, '0, rand_bits(32), t2, '0, t3);
        drain();

        // wakeup from the load lane
        exp_val[ext_tag] = rand_bits(32);
        done[ext_tag] = 1'b0;
        dispatch(rs_pkg::ALU_ADD, 1'b0, '0, '0, rand_bits(32), ext_tag, '0, t1);
        dispatch(rs_pkg::ALU_SRL, 1'b0, '0, t1, '0, '0, rand_bits(32), t2);
        repeat (3) step();
        ext_send();
        drain();

        // eight waiters spend every credit
        exp_val[ext_tag] = rand_bits(32);
        done[ext_tag] = 1'b0;
        for (int k = 0; k < 8; k++) begin
            dispatch(4'(k), 1'b0, '0, ext_tag, '0, '0, rand_bits(32), t1);
        end
        expect_credits(0);
        quiet = 1'b1;
        repeat (4) step();
        quiet = 1'b0;
        ext_send();
        drain();
        expect_credits(rs_pkg::RS_DEPTH);

        exp_val[ext_tag] = rand_bits(32);
        done[ext_tag] = 1'b0;
        for (int k = 0; k < 4; k++) begin
            dispatch(rs_pkg::ALU_ADD, 1'b0, '0, '0, rand_bits(32), ext_tag, '0, t1);
        end
        // this one sits on its issue port when the flush arrives
        dispatch(rs_pkg::ALU_ADD, 1'b0, '0, '0, rand_bits(32), '0, rand_bits(32), t2);
        step();
        flush = 1'b1;
        step();
        flush = 1'b0;
        pending = '0;
        // a late broadcast must not revive flushed entries
        quiet = 1'b1;
        ext_send();
        repeat (4) step();
        quiet = 1'b0;
        expect_credits(rs_pkg::RS_DEPTH);
        for (int k = 0; k < 8; k++) begin
            dispatch(4'(k), 1'b1, rand_bits(32), '0, rand_bits(32), '0, rand_bits(32), t1);
        end
        drain();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < 1500) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/rs_pkg.sv
rtl/rs_ctrl.sv
rtl/rs_entry_file.sv
rtl/rs_select.sv
rtl/alu_unit.sv
rtl/rs_top.sv
tests/rs_chk.sv
tests/rs_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := rs_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
